// File: logic/alu_pkg.sv
package alu_pkg;

    // Q6.10 signed fixed point
    localparam int int_w  = 6;
    localparam int frac_w = 10;
    localparam int data_w = int_w + frac_w;
    localparam int inst_w = 4;
    localparam int prod_w = 2 * data_w;  // full product

    typedef logic signed [data_w-1:0] data_t;

    localparam data_t fx_max = 16'h7fff;
    localparam data_t fx_min = 16'h8000;

    localparam int lfsr_max_steps = 8;

    // opcodes 4, 8 and 9 have no datapath behind them and return zero
    typedef enum logic [inst_w-1:0] {
        OP_FXADD = 4'd0,
        OP_FXSUB = 4'd1,
        OP_FXMUL = 4'd2,
        OP_FXMAC = 4'd3,
        OP_GELU  = 4'd4,
        OP_CLZ   = 4'd5,
        OP_LRCW  = 4'd6,
        OP_LFSR  = 4'd7,
        OP_FPADD = 4'd8,
        OP_FPSUB = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        SEQ_RESET = 2'd0,  // busy, not valid
        SEQ_IDLE  = 2'd1,  // first cycle out of reset
        SEQ_BUSY  = 2'd2,
        SEQ_DONE  = 2'd3   // result valid
    } seq_state_e;

endpackage

// File: logic/alu_operand_if.sv
`timescale 1ns/1ps

interface alu_operand_if;

    alu_pkg::data_t   data_a;
    alu_pkg::data_t   data_b;
    alu_pkg::alu_op_e op;
    alu_pkg::data_t   acc;    // previous valid result

    modport issue (
        output data_a,
        output data_b,
        output op,
        output acc
    );

    modport uses (
        input data_a,
        input data_b,
        input op,
        input acc
    );

endinterface

// File: logic/fixed_point_unit.sv
`timescale 1ns/1ps

module fixed_point_unit (
    alu_operand_if.uses    i_ops,
    output alu_pkg::data_t o_result
);

    logic signed [alu_pkg::data_w:0]   sum;
    logic signed [alu_pkg::data_w:0]   diff;
    logic signed [alu_pkg::prod_w-1:0] prod;
    logic signed [alu_pkg::prod_w-1:0] acc_wide;
    logic signed [alu_pkg::prod_w-1:0] mac;

    // clamp a 17-bit sum back into 16 bits
    function automatic alu_pkg::data_t clamp_sum(
        input logic signed [alu_pkg::data_w:0] value
    );
        if (value[alu_pkg::data_w] != value[alu_pkg::data_w-1]) begin
            return value[alu_pkg::data_w] ? alu_pkg::fx_min : alu_pkg::fx_max;
        end
        return value[alu_pkg::data_w-1:0];
    endfunction

    // 32-bit product with 20 fraction bits down to Q6.10
    function automatic alu_pkg::data_t scale_prod(
        input logic signed [alu_pkg::prod_w-1:0] value
    );
        logic [alu_pkg::prod_w-alu_pkg::data_w-alu_pkg::frac_w:0] upper;
        alu_pkg::data_t trunc;

        // in range only if bits 31:25 are all sign
        upper = value[alu_pkg::prod_w-1:alu_pkg::data_w+alu_pkg::frac_w-1];
        if (!(&upper) && (|upper)) begin
            return value[alu_pkg::prod_w-1] ? alu_pkg::fx_min : alu_pkg::fx_max;
        end

        trunc = value[alu_pkg::data_w+alu_pkg::frac_w-1:alu_pkg::frac_w];

        // round half up, held at max rather than wrapping
        if (value[alu_pkg::frac_w-1] && (trunc != alu_pkg::fx_max)) begin
            trunc = trunc + 1'b1;
        end
        return trunc;
    endfunction

    assign sum      = i_ops.data_a + i_ops.data_b;
    assign diff     = i_ops.data_a - i_ops.data_b;
    assign prod     = i_ops.data_a * i_ops.data_b;
    assign acc_wide = i_ops.acc;                       // sign extended
    assign mac      = prod + (acc_wide <<< alu_pkg::frac_w);

    always_comb begin
        case (i_ops.op)
            alu_pkg::OP_FXADD: o_result = clamp_sum(sum);
            alu_pkg::OP_FXSUB: o_result = clamp_sum(diff);
            alu_pkg::OP_FXMUL: o_result = scale_prod(prod);
            alu_pkg::OP_FXMAC: o_result = scale_prod(mac);
            default:           o_result = '0;            // bit unit or dropped op
        endcase
    end

endmodule

// File: logic/bit_manip_unit.sv
`timescale 1ns/1ps

module bit_manip_unit (
    alu_operand_if.uses    i_ops,
    output alu_pkg::data_t o_result
);

    function automatic alu_pkg::data_t count_lz(input alu_pkg::data_t value);
        alu_pkg::data_t count;
        logic           seen;

        count = '0;
        seen  = 1'b0;
        for (int i = alu_pkg::data_w - 1; i >= 0; i--) begin
            if (value[i]) begin
                seen = 1'b1;
            end else if (!seen) begin
                count = count + 1'b1;
            end
        end
        return count;  // 16 for zero
    endfunction

    function automatic logic [$clog2(alu_pkg::data_w+1)-1:0] popcount(
        input alu_pkg::data_t value
    );
        logic [$clog2(alu_pkg::data_w+1)-1:0] count;

        count = '0;
        for (int i = 0; i < alu_pkg::data_w; i++) begin
            count = count + value[i];
        end
        return count;
    endfunction

    // rotate b left by popcount(a), wrapped bits come back inverted
    function automatic alu_pkg::data_t lrcw(
        input alu_pkg::data_t a,
        input alu_pkg::data_t b
    );
        logic [$clog2(alu_pkg::data_w+1)-1:0] n;
        logic [2*alu_pkg::data_w-1:0]         wide;

        n    = popcount(a);
        wide = {b, ~b} << n;
        return wide[2*alu_pkg::data_w-1:alu_pkg::data_w];
    endfunction

    function automatic alu_pkg::data_t lfsr_step(input alu_pkg::data_t value);
        logic fb;

        fb = value[15] ^ value[13] ^ value[12] ^ value[10];  // taps 16,14,13,11
        return {value[alu_pkg::data_w-2:0], fb};
    endfunction

    function automatic alu_pkg::data_t lfsr(
        input alu_pkg::data_t seed,
        input alu_pkg::data_t steps
    );
        alu_pkg::data_t state;

        if ($unsigned(steps) > alu_pkg::lfsr_max_steps) begin
            return '0;
        end
        state = seed;
        for (int i = 0; i < alu_pkg::lfsr_max_steps; i++) begin
            if (i < int'(steps)) begin
                state = lfsr_step(state);
            end
        end
        return state;
    endfunction

    always_comb begin
        case (i_ops.op)
            alu_pkg::OP_CLZ:  o_result = count_lz(i_ops.data_a);
            alu_pkg::OP_LRCW: o_result = lrcw(i_ops.data_a, i_ops.data_b);
            alu_pkg::OP_LFSR: o_result = lfsr(i_ops.data_a, i_ops.data_b);
            default:          o_result = '0;
        endcase
    end

endmodule

// File: logic/alu_sequencer.sv
`timescale 1ns/1ps

module alu_sequencer (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  alu_pkg::data_t     i_data_a,
    input  alu_pkg::data_t     i_data_b,
    input  alu_pkg::alu_op_e   i_inst,
    input  alu_pkg::data_t     i_fx_result,
    input  alu_pkg::data_t     i_bit_result,
    alu_operand_if.issue       o_ops,
    output alu_pkg::data_t     o_data,
    output logic               o_busy,
    output logic               o_valid
);

    alu_pkg::seq_state_e state_q;
    alu_pkg::seq_state_e state_d;
    alu_pkg::data_t      acc_q;

    assign o_ops.data_a = i_data_a;
    assign o_ops.data_b = i_data_b;
    assign o_ops.op     = i_inst;
    assign o_ops.acc    = acc_q;

    // units drive zero outside their own opcodes
    assign o_data = i_fx_result | i_bit_result;

    always_comb begin
        case (state_q)
            alu_pkg::SEQ_RESET: state_d = alu_pkg::SEQ_IDLE;
            alu_pkg::SEQ_IDLE:  state_d = alu_pkg::SEQ_BUSY;
            alu_pkg::SEQ_BUSY:  state_d = alu_pkg::SEQ_DONE;
            alu_pkg::SEQ_DONE:  state_d = alu_pkg::SEQ_BUSY;
            default:            state_d = alu_pkg::SEQ_BUSY;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= alu_pkg::SEQ_RESET;
            acc_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == alu_pkg::SEQ_DONE) begin
                acc_q <= o_data;  // keep last valid result for mac
            end
        end
    end

    assign o_busy  = (state_q == alu_pkg::SEQ_RESET) || (state_q == alu_pkg::SEQ_BUSY);
    assign o_valid = (state_q == alu_pkg::SEQ_DONE);

endmodule

// File: logic/alu_top.sv
`timescale 1ns/1ps

module alu_top (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [15:0] i_data_a,
    input  logic [15:0] i_data_b,
    input  logic [3:0]  i_inst,
    output logic        o_valid,
    output logic        o_busy,
    output logic [15:0] o_data
);

    alu_pkg::data_t fx_result;
    alu_pkg::data_t bit_result;

    alu_operand_if ops_if ();

    alu_sequencer seq0 (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_data_a     (i_data_a),
        .i_data_b     (i_data_b),
        .i_inst       (alu_pkg::alu_op_e'(i_inst)),  // codes 10..15 pass through
        .i_fx_result  (fx_result),
        .i_bit_result (bit_result),
        .o_ops        (ops_if.issue),
        .o_data       (o_data),
        .o_busy       (o_busy),
        .o_valid      (o_valid)
    );

    fixed_point_unit fx0 (
        .i_ops    (ops_if.uses),
        .o_result (fx_result)
    );

    bit_manip_unit bit0 (
        .i_ops    (ops_if.uses),
        .o_result (bit_result)
    );

endmodule

// File: dv/alu_properties.sv
`timescale 1ns/1ps

module alu_properties (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_busy,
    input logic i_valid
);

    // one of the two at most
    assert property (@(posedge i_clk) disable iff (!i_rst_n) !(i_busy && i_valid))
        else $error("o_busy and o_valid high in the same cycle");

    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_valid |=> !i_valid)
        else $error("o_valid high in two consecutive cycles");

    // done always goes back to busy
    assert property (@(posedge i_clk) disable iff (!i_rst_n) i_valid |=> i_busy)
        else $error("o_valid not followed by o_busy");

    assert property (@(posedge i_clk) !i_rst_n |-> !i_valid)
        else $error("o_valid high while reset is asserted");

endmodule

bind alu_sequencer alu_properties props0 (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_busy  (o_busy),
    .i_valid (o_valid)
);

// File: dv/alu_tb.sv
`timescale 1ns/1ps

module alu_tb;

    localparam int seed_init      = 32'h16e0_675c;
    localparam int random_count   = 20;
    localparam int timeout_cycles = 10;

    logic        clk;
    logic        rst_n;
    logic [15:0] data_a;
    logic [15:0] data_b;
    logic [3:0]  inst;
    logic        valid;
    logic        busy;
    logic [15:0] data;

    integer      seed;
    logic [15:0] model_acc;    // mirrors the accumulator
    int          check_count;
    int          error_count;
    int          test_checks;
    int          test_errors;
    bit          timed_out;

    alu_top dut0 (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_data_a (data_a),
        .i_data_b (data_b),
        .i_inst   (inst),
        .o_valid  (valid),
        .o_busy   (busy),
        .o_data   (data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic start_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        $display("test %-9s %0d checks, %0d errors", name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    function automatic logic [15:0] next_random();
        int r;

        r = $random(seed);
        return r[15:0];
    endfunction

    // roughly -1.0 .. 1.0 in Q6.10
    function automatic logic [15:0] small_random();
        logic [15:0] r;

        r = next_random();
        return {{5{r[10]}}, r[10:0]};
    endfunction

    function automatic logic [15:0] clamp16(input int value);
        if (value > 32767) return 16'h7fff;
        if (value < -32768) return 16'h8000;
        return value[15:0];
    endfunction

    // 20 fraction bits down to 10, round half up
    function automatic logic [15:0] scale_product(input longint product);
        longint scaled;

        if (product < -33554432) return 16'h8000;
        if (product > 33554431) return 16'h7fff;
        scaled = product >>> 10;
        if (product[9] && scaled != 32767) begin
            scaled++;
        end
        return scaled[15:0];
    endfunction

    function automatic logic [15:0] leading_zeros(input logic [15:0] value);
        int count;

        count = 0;
        while (count < 16 && !value[15 - count]) begin
            count++;
        end
        return 16'(count);
    endfunction

    function automatic logic [15:0] rotate_complement(input logic [15:0] a,
                                                      input logic [15:0] b);
        logic [15:0] r;

        r = b;
        for (int i = 0; i < $countones(a); i++) begin
            r = {r[14:0], ~r[15]};  // top bit wraps in inverted
        end
        return r;
    endfunction

    function automatic logic [15:0] lfsr_model(input logic [15:0] seed_value,
                                               input logic [15:0] steps);
        logic [15:0] s;

        if (steps > 16'd8) return 16'h0000;
        s = seed_value;
        for (int i = 0; i < int'(steps); i++) begin
            s = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        end
        return s;
    endfunction

    function automatic logic [15:0] expected_result(input logic [3:0] op,
                                                    input logic [15:0] a,
                                                    input logic [15:0] b);
        longint sa;
        longint sb;

        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (op)
            alu_pkg::OP_FXADD: return clamp16(int'(sa + sb));
            alu_pkg::OP_FXSUB: return clamp16(int'(sa - sb));
            alu_pkg::OP_FXMUL: return scale_product(sa * sb);
            alu_pkg::OP_FXMAC: return scale_product(sa * sb + longint'($signed(model_acc)) * 1024);
            alu_pkg::OP_CLZ:   return leading_zeros(a);
            alu_pkg::OP_LRCW:  return rotate_complement(a, b);
            alu_pkg::OP_LFSR:  return lfsr_model(a, b);
            default:           return 16'h0000;  // dropped and unused codes
        endcase
    endfunction

    task automatic wait_valid(output bit ok);
        int cycles;

        cycles = 0;
        ok = 1'b1;
        @(negedge clk);
        while (!valid && ok) begin
            if (cycles == timeout_cycles) begin
                $display("timeout: o_valid did not rise within %0d cycles", timeout_cycles);
                error_count++;
                timed_out = 1'b1;
                ok = 1'b0;
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // starts at the falling edge of a done cycle, ends at the next one
    task automatic run_op(input string name, input logic [3:0] op,
                          input logic [15:0] a, input logic [15:0] b);
        logic [15:0] expected;
        bit          ok;

        if (timed_out) return;
        @(posedge clk);
        inst   <= op;
        data_a <= a;
        data_b <= b;
        expected = expected_result(op, a, b);
        wait_valid(ok);
        if (ok) begin
            check_value(name, expected, data);
            model_acc = expected;
        end
    endtask

    initial begin
        logic busy_exp;
        logic valid_exp;

        seed        = seed_init;
        rst_n       = 1'b0;
        data_a      = 16'h0000;
        data_b      = 16'h0000;
        inst        = alu_pkg::OP_FXADD;
        model_acc   = 16'h0000;
        check_count = 0;
        error_count = 0;
        timed_out   = 1'b0;

        start_test();
        for (int i = 0; i < 5; i++) begin
            @(negedge clk);
            check_value("reset_busy", 16'd1, 16'(busy));
            check_value("reset_valid", 16'd0, 16'(valid));
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);  // reset was still sampled low at the release edge
        for (int k = 1; k <= 7; k++) begin
            @(negedge clk);
            busy_exp  = (k != 1) && (k % 2 == 0);
            valid_exp = (k >= 3) && (k % 2 == 1);
            check_value($sformatf("cadence_busy_%0d", k), 16'(busy_exp), 16'(busy));
            check_value($sformatf("cadence_valid_%0d", k), 16'(valid_exp), 16'(valid));
        end
        check_value("cadence_data", 16'h0000, data);
        end_test("cadence");

        start_test();
        for (int i = 0; i < random_count; i++) begin
            run_op("fxadd_rand", alu_pkg::OP_FXADD, next_random(), next_random());
            run_op("fxsub_rand", alu_pkg::OP_FXSUB, next_random(), next_random());
        end
        run_op("fxadd_max", alu_pkg::OP_FXADD, 16'h7fff, 16'h0001);
        run_op("fxadd_min", alu_pkg::OP_FXADD, 16'h8000, 16'hffff);
        run_op("fxsub_max", alu_pkg::OP_FXSUB, 16'h7fff, 16'hffff);
        run_op("fxsub_min", alu_pkg::OP_FXSUB, 16'h8000, 16'h0001);
        end_test("add_sub");

        start_test();
        for (int i = 0; i < random_count; i++) begin
            run_op("fxmul_rand", alu_pkg::OP_FXMUL, next_random(), next_random());
            run_op("fxmul_small", alu_pkg::OP_FXMUL, small_random(), small_random());
        end
        run_op("fxmul_max", alu_pkg::OP_FXMUL, 16'h7fff, 16'h7fff);
        run_op("fxmul_min", alu_pkg::OP_FXMUL, 16'h8000, 16'h7fff);
        run_op("fxmul_neg", alu_pkg::OP_FXMUL, 16'h8000, 16'h8000);
        run_op("fxmul_round", alu_pkg::OP_FXMUL, 16'h0001, 16'h0200);
        run_op("fxmul_rndsat", alu_pkg::OP_FXMUL, 16'h4040, 16'h07f8);  // rounds into max
        for (int i = 0; i < random_count / 2; i++) begin
            run_op($sformatf("fxmac_chain_%0d", i), alu_pkg::OP_FXMAC,
                   small_random(), small_random());
        end
        end_test("mul_mac");

        start_test();
        for (int i = 0; i < random_count; i++) begin
            run_op("clz_rand", alu_pkg::OP_CLZ, next_random() >> (i % 16), next_random());
            run_op("lrcw_rand", alu_pkg::OP_LRCW, next_random(), next_random());
        end
        run_op("clz_zero", alu_pkg::OP_CLZ, 16'h0000, 16'h0000);
        run_op("clz_ones", alu_pkg::OP_CLZ, 16'hffff, 16'h0000);
        run_op("clz_one", alu_pkg::OP_CLZ, 16'h0001, 16'h0000);
        run_op("lrcw_pop0", alu_pkg::OP_LRCW, 16'h0000, next_random());
        run_op("lrcw_pop16", alu_pkg::OP_LRCW, 16'hffff, next_random());
        run_op("lrcw_zero", alu_pkg::OP_LRCW, 16'h0000, 16'h0000);
        end_test("clz_lrcw");

        start_test();
        for (int steps = 0; steps <= 8; steps++) begin
            run_op($sformatf("lfsr_steps_%0d", steps), alu_pkg::OP_LFSR,
                   next_random(), 16'(steps));
        end
        run_op("lfsr_over_9", alu_pkg::OP_LFSR, next_random(), 16'd9);
        run_op("lfsr_over_200", alu_pkg::OP_LFSR, next_random(), 16'd200);
        run_op("lfsr_over_ffff", alu_pkg::OP_LFSR, next_random(), 16'hffff);
        end_test("lfsr");

        start_test();
        run_op("gelu", alu_pkg::OP_GELU, next_random(), next_random());
        run_op("fpadd", alu_pkg::OP_FPADD, next_random(), next_random());
        run_op("fpsub", alu_pkg::OP_FPSUB, next_random(), next_random());
        for (int code = 10; code < 16; code++) begin
            run_op($sformatf("op_%0d", code), 4'(code), next_random(), next_random());
        end
        end_test("dropped");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
logic/alu_pkg.sv
logic/alu_operand_if.sv
logic/fixed_point_unit.sv
logic/bit_manip_unit.sv
logic/alu_sequencer.sv
logic/alu_top.sv
dv/alu_properties.sv
dv/alu_tb.sv

// File: Makefile
TOP  := alu_tb
SRCS := $(shell grep '\.sv$$' list.f)

.PHONY: run clean

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

obj_dir/V$(TOP): list.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir sim.log
